/* Bender.yml */
package:
  name: aud_rec_play

sources:
  - include_dirs:
      - include
    files:
      - design/aud_data_pkg.sv
      - design/aud_ctrl_pkg.sv
      - design/aud_sample_ram.sv
      - design/aud_i2s_rx.sv
      - design/aud_i2s_tx.sv
      - design/aud_ctrl.sv
      - design/aud_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/aud_tb.sv

/* bench/aud_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_consts.svh"

module aud_tb;

    localparam int FRAME_CYC = 64;
    localparam int HALF_CYC  = 32;
    localparam int W         = `AUD_SAMPLE_W;
    localparam int NUM_TESTS = 5;
    localparam int CMD_NONE  = 0;
    localparam int CMD_REC   = 1;
    localparam int CMD_PLAY  = 2;
    localparam int CMD_PAUSE = 3;
    localparam int CMD_STOP  = 4;

    // one test: stored frames, pause point and length, stop cycle, fill, wrong-mode commands.
    typedef struct packed {
        logic [7:0] rec_frames;
        logic [7:0] pause_after;
        logic [7:0] pause_frames;
        logic [7:0] stop_cycle;
        logic       fill;
        logic       wrong_cmd;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  rec;
    logic                  play;
    logic                  pause;
    logic                  stop;
    logic                  lrc;
    logic                  adc_dat;
    logic                  dac_dat;
    aud_data_pkg::addr_t   addr;
    aud_data_pkg::addr_t   len;
    logic                  busy;
    logic                  done;

    row_t                  tests [NUM_TESTS];
    aud_data_pkg::sample_t exp_q [$];
    aud_data_pkg::sample_t dac_word;
    logic [15:0]           lfsr_q;
    int                    dac_stray;
    int                    frame_done;
    int                    err_cnt;
    int                    chk_cnt;
    longint                watchdog_ns;
    bit                    table_loaded;

    aud_top dut0 (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_rec     (rec),
        .i_play    (play),
        .i_pause   (pause),
        .i_stop    (stop),
        .i_lrc     (lrc),
        .i_adc_dat (adc_dat),
        .o_dac_dat (dac_dat),
        .o_addr    (addr),
        .o_len     (len),
        .o_busy    (busy),
        .o_done    (done)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic row_t make_row(input int frames, input int p_after, input int p_len,
                                      input int stop_at, input bit fill, input bit wrong);
        row_t r;
        r.rec_frames   = 8'(frames);
        r.pause_after  = 8'(p_after);
        r.pause_frames = 8'(p_len);
        r.stop_cycle   = 8'(stop_at);
        r.fill         = fill;
        r.wrong_cmd    = wrong;
        return r;
    endfunction

    function automatic int frames_in_table();
        int n;
        int i;
        n = 0;
        for (i = 0; i < NUM_TESTS; i++) begin
            n += 2 * (tests[i].fill ? `AUD_RAM_DEPTH : int'(tests[i].rec_frames));
            n += int'(tests[i].pause_frames) + 8;
        end
        return n;
    endfunction

    task automatic check_sample(input string name, input aud_data_pkg::sample_t got,
                                input aud_data_pkg::sample_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input aud_data_pkg::addr_t got,
                              input aud_data_pkg::addr_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_done_pulses(input int want, input string what);
        chk_cnt++;
        if (frame_done != want) begin
            $display("%0t: %s gave %0d o_done pulses in the frame instead of %0d",
                     $time, what, frame_done, want);
            err_cnt++;
        end
    endtask

    // one codec frame; left bits in cycles 1..16, right bits in 33..48.
    task automatic run_frame(input int cmd, input int cmd_cycle, input bit keep);
        aud_data_pkg::sample_t left;
        aud_data_pkg::sample_t right;
        int t;
        for (t = 0; t < 2 * W; t++) begin
            lfsr_q = lfsr_step(lfsr_q);
            if (t < W) left = {left[W-2:0], lfsr_q[0]};
            else right = {right[W-2:0], lfsr_q[0]};
        end
        if (keep) exp_q.push_back(left);
        frame_done = 0;
        dac_stray  = 0;
        dac_word   = '0;
        for (t = 0; t < FRAME_CYC; t++) begin
            @(posedge clk);
            #1;
            lrc = (t >= HALF_CYC);
            if (t >= 1 && t <= W) adc_dat = left[W-t];
            else if (t > HALF_CYC && t <= HALF_CYC + W) adc_dat = right[HALF_CYC+W-t];
            else adc_dat = 1'b0;
            rec   = (cmd == CMD_REC) && (t == cmd_cycle);
            play  = (cmd == CMD_PLAY) && (t == cmd_cycle);
            pause = (cmd == CMD_PAUSE) && (t == cmd_cycle);
            stop  = (cmd == CMD_STOP) && (t == cmd_cycle);
            @(negedge clk);
            if (done === 1'b1) frame_done++;
            if (t >= 1 && t <= W) dac_word = {dac_word[W-2:0], dac_dat};
            else if (dac_dat !== 1'b0) dac_stray++;
        end
    endtask

    // pause cuts the current word, resume just before the next frame.
    task automatic pause_gap(input int n);
        int p;
        run_frame(CMD_PAUSE, 8, 1'b0);
        check_flag("o_busy", busy, 1'b1);
        for (p = 0; p < n; p++) begin
            run_frame((p == n - 1) ? CMD_PAUSE : CMD_NONE, 40, 1'b0);
            expect_done_pulses(0, "paused frame");
            check_addr("o_addr", addr, aud_data_pkg::addr_t'(exp_q.size()));
        end
    endtask

    task automatic record_take(input row_t row);
        int f;
        int total;
        if (row.wrong_cmd) begin
            run_frame(CMD_STOP, 40, 1'b0);
            expect_done_pulses(0, "stop while idle");
            check_flag("o_busy", busy, 1'b0);
        end
        run_frame(CMD_REC, 40, 1'b0);
        check_flag("o_busy", busy, 1'b1);
        check_addr("o_addr", addr, '0);
        total = row.fill ? `AUD_RAM_DEPTH : int'(row.rec_frames);
        for (f = 0; f < total; f++) begin
            if (row.pause_frames != 0 && f == int'(row.pause_after)) pause_gap(row.pause_frames);
            run_frame((row.wrong_cmd && f == 1) ? CMD_PLAY : CMD_NONE, 40, 1'b1);
            if (row.fill && f == total - 1) begin
                expect_done_pulses(1, "memory full");
                check_flag("o_busy", busy, 1'b0);
                check_addr("o_len", len, aud_data_pkg::addr_t'(`AUD_RAM_DEPTH));
            end else begin
                expect_done_pulses(0, "recording");
                check_flag("o_busy", busy, 1'b1);
                check_addr("o_addr", addr, aud_data_pkg::addr_t'(exp_q.size()));
            end
        end
        if (!row.fill) begin
            // the word survives only if its last bit came before the stop.
            run_frame(CMD_STOP, row.stop_cycle, row.stop_cycle > W);
            expect_done_pulses(1, "stop while recording");
            check_flag("o_busy", busy, 1'b0);
            check_addr("o_len", len, aud_data_pkg::addr_t'(exp_q.size()));
        end
    endtask

    task automatic play_back();
        int n;
        int k;
        aud_data_pkg::sample_t want;
        n = exp_q.size();
        run_frame(CMD_PLAY, 40, 1'b0);
        check_flag("o_busy", busy, 1'b1);
        check_addr("o_addr", addr, '0);
        for (k = 0; k < n; k++) begin
            run_frame(CMD_NONE, 0, 1'b0);
            want = exp_q.pop_front();
            check_sample("o_dac_dat", dac_word, want);
            if (dac_stray != 0) begin
                $display("%0t: o_dac_dat was high outside the left slot", $time);
                err_cnt++;
            end
            expect_done_pulses(0, "playback");
        end
        run_frame(CMD_NONE, 0, 1'b0);
        expect_done_pulses(1, "end of playback");
        check_flag("o_busy", busy, 1'b0);
        check_sample("o_dac_dat", dac_word, '0);
    endtask

    initial begin
        wait (table_loaded);
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Something failed");
        $finish;
    end

    initial begin
        int i;
        int err_start;
        clk     = 1'b0;
        rst_n   = 1'b1;
        rec     = 1'b0;
        play    = 1'b0;
        pause   = 1'b0;
        stop    = 1'b0;
        lrc     = 1'b1;
        adc_dat = 1'b0;
        lfsr_q  = 16'd57;
        err_cnt = 0;
        chk_cnt = 0;
        tests[0] = make_row(3, 0, 0, 40, 1'b0, 1'b1);
        tests[1] = make_row(4, 0, 0, 8, 1'b0, 1'b0);
        tests[2] = make_row(5, 2, 3, 40, 1'b0, 1'b0);
        tests[3] = make_row(2, 1, 1, 8, 1'b0, 1'b0);
        tests[4] = make_row(0, 0, 0, 0, 1'b1, 1'b0);
        watchdog_ns  = longint'(frames_in_table() + 20) * FRAME_CYC * 8;
        table_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b0;
        @(negedge clk);
        check_flag("o_busy", busy, 1'b0);
        check_flag("o_done", done, 1'b0);
        check_flag("o_dac_dat", dac_dat, 1'b0);
        check_addr("o_addr", addr, '0);
        check_addr("o_len", len, '0);
        $display("reset test finished with %0d errors", err_cnt);
        for (i = 0; i < NUM_TESTS; i++) begin
            err_start = err_cnt;
            record_take(tests[i]);
            play_back();
            $display("test %0d (frames %0d, pause %0d+%0d, stop at %0d, fill %0d): %0d errors",
                     i, tests[i].rec_frames, tests[i].pause_after, tests[i].pause_frames,
                     tests[i].stop_cycle, tests[i].fill, err_cnt - err_start);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/aud_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_consts.svh"

module aud_ctrl (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           i_rec,
    input  wire logic           i_play,
    input  wire logic           i_pause,
    input  wire logic           i_stop,
    input  wire logic           i_lrc,
    input  wire logic           i_wr,
    output logic                o_rx_frame,
    output logic                o_rx_abort,
    output logic                o_tx_frame,
    output logic                o_ram_we,
    output logic                o_ram_re,
    output aud_data_pkg::addr_t o_ram_addr,
    output aud_data_pkg::addr_t o_addr,
    output aud_data_pkg::addr_t o_len,
    output logic                o_busy,
    output logic                o_done
);

    localparam aud_data_pkg::addr_t LAST_ADDR = aud_data_pkg::addr_t'(`AUD_RAM_DEPTH - 1);
    localparam aud_data_pkg::addr_t ADDR_ONE  = aud_data_pkg::addr_t'(1);

    aud_ctrl_pkg::mode_t mode_q, mode_d;
    aud_ctrl_pkg::cmd_t  cmd;
    aud_data_pkg::addr_t addr_q, addr_d;
    aud_data_pkg::addr_t len_q, len_d;
    logic                lrc_q;
    logic                full_q, full_d;
    logic                played_q, played_d;
    logic                done_q, done_d;
    logic                frame_start;
    logic                play_end;

    // left slot begins on the falling edge of lrc.
    assign frame_start = lrc_q & ~i_lrc;

    // a full recording wraps len to 0, so wait for the first read before ending.
    assign play_end = frame_start && (mode_q == aud_ctrl_pkg::mode_play) &&
                      (addr_q == len_q) && (!full_q || played_q);

    assign o_rx_frame = frame_start && (mode_q == aud_ctrl_pkg::mode_rec);
    assign o_tx_frame = frame_start && (mode_q == aud_ctrl_pkg::mode_play) && !play_end;
    assign o_ram_we   = i_wr && (mode_q == aud_ctrl_pkg::mode_rec);
    assign o_ram_re   = o_tx_frame;
    assign o_rx_abort = (mode_q == aud_ctrl_pkg::mode_rec) &&
                        ((cmd == aud_ctrl_pkg::cmd_pause) || (cmd == aud_ctrl_pkg::cmd_stop));

    assign o_ram_addr = addr_q;
    assign o_addr     = addr_q;
    assign o_len      = len_q;
    assign o_busy     = (mode_q != aud_ctrl_pkg::mode_idle);
    assign o_done     = done_q;

    always_comb begin
        if (i_stop) begin
            cmd = aud_ctrl_pkg::cmd_stop;
        end else if (i_pause) begin
            cmd = aud_ctrl_pkg::cmd_pause;
        end else if (i_rec) begin
            cmd = aud_ctrl_pkg::cmd_rec;
        end else if (i_play) begin
            cmd = aud_ctrl_pkg::cmd_play;
        end else begin
            cmd = aud_ctrl_pkg::cmd_none;
        end
    end

    always_comb begin
        mode_d   = mode_q;
        addr_d   = addr_q;
        len_d    = len_q;
        full_d   = full_q;
        played_d = played_q;
        done_d   = 1'b0;

        // every memory access moves to the next word.
        if (o_ram_we || o_ram_re) begin
            addr_d = addr_q + ADDR_ONE;
        end
        if (o_ram_re) begin
            played_d = 1'b1;
        end

        case (mode_q)
            aud_ctrl_pkg::mode_idle: begin
                if (cmd == aud_ctrl_pkg::cmd_rec) begin
                    mode_d = aud_ctrl_pkg::mode_rec;
                    addr_d = '0;
                    len_d  = '0;
                    full_d = 1'b0;
                end else if (cmd == aud_ctrl_pkg::cmd_play) begin
                    mode_d   = aud_ctrl_pkg::mode_play;
                    addr_d   = '0;
                    played_d = 1'b0;
                end
            end
            aud_ctrl_pkg::mode_rec: begin
                if (o_ram_we && (addr_q == LAST_ADDR)) begin
                    // memory full.
                    mode_d = aud_ctrl_pkg::mode_idle;
                    len_d  = addr_d;
                    full_d = 1'b1;
                    done_d = 1'b1;
                end else if (cmd == aud_ctrl_pkg::cmd_stop) begin
                    mode_d = aud_ctrl_pkg::mode_idle;
                    len_d  = addr_d;
                    done_d = 1'b1;
                end else if (cmd == aud_ctrl_pkg::cmd_pause) begin
                    mode_d = aud_ctrl_pkg::mode_rec_pause;
                end
            end
            aud_ctrl_pkg::mode_rec_pause: begin
                if (cmd == aud_ctrl_pkg::cmd_stop) begin
                    mode_d = aud_ctrl_pkg::mode_idle;
                    len_d  = addr_q;
                    done_d = 1'b1;
                end else if (cmd == aud_ctrl_pkg::cmd_pause) begin
                    mode_d = aud_ctrl_pkg::mode_rec;
                end
            end
            aud_ctrl_pkg::mode_play: begin
                if (play_end || (cmd == aud_ctrl_pkg::cmd_stop)) begin
                    mode_d = aud_ctrl_pkg::mode_idle;
                    done_d = 1'b1;
                end else if (cmd == aud_ctrl_pkg::cmd_pause) begin
                    mode_d = aud_ctrl_pkg::mode_play_pause;
                end
            end
            aud_ctrl_pkg::mode_play_pause: begin
                if (cmd == aud_ctrl_pkg::cmd_stop) begin
                    mode_d = aud_ctrl_pkg::mode_idle;
                    done_d = 1'b1;
                end else if (cmd == aud_ctrl_pkg::cmd_pause) begin
                    mode_d = aud_ctrl_pkg::mode_play;
                end
            end
            default: begin
                mode_d = aud_ctrl_pkg::mode_idle;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            mode_q   <= aud_ctrl_pkg::mode_idle;
            lrc_q    <= 1'b0;
            addr_q   <= '0;
            len_q    <= '0;
            full_q   <= 1'b0;
            played_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            mode_q   <= mode_d;
            lrc_q    <= i_lrc;
            addr_q   <= addr_d;
            len_q    <= len_d;
            full_q   <= full_d;
            played_q <= played_d;
            done_q   <= done_d;
        end
    end

endmodule

`default_nettype wire

/* design/aud_ctrl_pkg.sv */
`default_nettype none

package aud_ctrl_pkg;

    // controller modes.
    typedef enum logic [2:0] {
        mode_idle,
        mode_rec,
        mode_rec_pause,
        mode_play,
        mode_play_pause
    } mode_t;

    // one decoded command per cycle, stop wins over pause.
    typedef enum logic [2:0] {
        cmd_none,
        cmd_rec,
        cmd_play,
        cmd_pause,
        cmd_stop
    } cmd_t;

endpackage

`default_nettype wire

/* design/aud_data_pkg.sv */
`default_nettype none

package aud_data_pkg;

`include "aud_consts.svh"

    // one left-channel sample.
    typedef logic [`AUD_SAMPLE_W-1:0] sample_t;

    // word address into the sample memory.
    typedef logic [`AUD_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

/* design/aud_i2s_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_consts.svh"

module aud_i2s_rx (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_frame,
    input  wire logic             i_abort,
    input  wire logic             i_adc_dat,
    output logic                  o_wr,
    output aud_data_pkg::sample_t o_sample
);

    localparam int CNT_W = $clog2(`AUD_SAMPLE_W + 1);

    localparam logic [CNT_W-1:0] BITS    = CNT_W'(`AUD_SAMPLE_W);
    localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);

    logic [CNT_W-1:0]      bits_left_q;
    logic                  wr_q;
    aud_data_pkg::sample_t shift_q;

    assign o_wr     = wr_q;
    assign o_sample = shift_q;

    // counter and strobe.
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            bits_left_q <= '0;
            wr_q        <= 1'b0;
        end else begin
            wr_q <= 1'b0;
            if (i_abort) begin
                // partial word is dropped.
                bits_left_q <= '0;
            end else if (i_frame) begin
                bits_left_q <= BITS;
            end else if (bits_left_q != '0) begin
                bits_left_q <= bits_left_q - CNT_ONE;
                if (bits_left_q == CNT_ONE) begin
                    wr_q <= 1'b1;
                end
            end
        end
    end

    // msb arrives first.
    always_ff @(posedge i_clk) begin
        if (!i_abort && !i_frame && (bits_left_q != '0)) begin
            shift_q <= {shift_q[`AUD_SAMPLE_W-2:0], i_adc_dat};
        end
    end

endmodule

`default_nettype wire

/* design/aud_i2s_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_consts.svh"

module aud_i2s_tx (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_frame,
    input  wire aud_data_pkg::sample_t i_rd_data,
    output logic                       o_dac_dat
);

    localparam int CNT_W = $clog2(`AUD_SAMPLE_W);

    localparam logic [CNT_W-1:0] REST    = CNT_W'(`AUD_SAMPLE_W - 1);
    localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);

    logic                      frame_q;
    logic [CNT_W-1:0]          bits_left_q;
    logic [`AUD_SAMPLE_W-2:0]  shift_q;

    // memory data is valid the cycle after the frame strobe.
    assign o_dac_dat = frame_q ? i_rd_data[`AUD_SAMPLE_W-1] :
                       ((bits_left_q != '0) && shift_q[`AUD_SAMPLE_W-2]);

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            frame_q     <= 1'b0;
            bits_left_q <= '0;
        end else begin
            frame_q <= i_frame;
            if (frame_q) begin
                bits_left_q <= REST;
            end else if (bits_left_q != '0) begin
                bits_left_q <= bits_left_q - CNT_ONE;
            end
        end
    end

    // remaining bits, msb side first.
    always_ff @(posedge i_clk) begin
        if (frame_q) begin
            shift_q <= i_rd_data[`AUD_SAMPLE_W-2:0];
        end else if (bits_left_q != '0) begin
            shift_q <= {shift_q[`AUD_SAMPLE_W-3:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* design/aud_sample_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aud_consts.svh"

module aud_sample_ram (
    input  wire logic                  i_clk,
    input  wire logic                  i_we,
    input  wire logic                  i_re,
    input  wire aud_data_pkg::addr_t   i_addr,
    input  wire aud_data_pkg::sample_t i_wdata,
    output aud_data_pkg::sample_t      o_rdata
);

    aud_data_pkg::sample_t mem [`AUD_RAM_DEPTH];
    aud_data_pkg::sample_t rdata_q;

    assign o_rdata = rdata_q;

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // read register holds its value between reads.
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            rdata_q <= mem[i_addr];
        end
    end

endmodule

`default_nettype wire

/* design/aud_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aud_top (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_rec,
    input  wire logic                 i_play,
    input  wire logic                 i_pause,
    input  wire logic                 i_stop,
    input  wire logic                 i_lrc,
    input  wire logic                 i_adc_dat,
    output wire logic                 o_dac_dat,
    output wire aud_data_pkg::addr_t  o_addr,
    output wire aud_data_pkg::addr_t  o_len,
    output wire logic                 o_busy,
    output wire logic                 o_done
);

    logic                  rx_frame;
    logic                  rx_abort;
    logic                  rx_wr;
    aud_data_pkg::sample_t rx_sample;
    logic                  tx_frame;
    logic                  ram_we;
    logic                  ram_re;
    aud_data_pkg::addr_t   ram_addr;
    aud_data_pkg::sample_t ram_rdata;

    aud_ctrl u_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rec      (i_rec),
        .i_play     (i_play),
        .i_pause    (i_pause),
        .i_stop     (i_stop),
        .i_lrc      (i_lrc),
        .i_wr       (rx_wr),
        .o_rx_frame (rx_frame),
        .o_rx_abort (rx_abort),
        .o_tx_frame (tx_frame),
        .o_ram_we   (ram_we),
        .o_ram_re   (ram_re),
        .o_ram_addr (ram_addr),
        .o_addr     (o_addr),
        .o_len      (o_len),
        .o_busy     (o_busy),
        .o_done     (o_done)
    );

    // recorder side.
    aud_i2s_rx u_rx (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_frame   (rx_frame),
        .i_abort   (rx_abort),
        .i_adc_dat (i_adc_dat),
        .o_wr      (rx_wr),
        .o_sample  (rx_sample)
    );

    // player side.
    aud_i2s_tx u_tx (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_frame   (tx_frame),
        .i_rd_data (ram_rdata),
        .o_dac_dat (o_dac_dat)
    );

    aud_sample_ram u_ram (
        .i_clk   (i_clk),
        .i_we    (ram_we),
        .i_re    (ram_re),
        .i_addr  (ram_addr),
        .i_wdata (rx_sample),
        .o_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
design/aud_data_pkg.sv
design/aud_ctrl_pkg.sv
design/aud_sample_ram.sv
design/aud_i2s_rx.sv
design/aud_i2s_tx.sv
design/aud_ctrl.sv
design/aud_top.sv
bench/aud_tb.sv

/* include/aud_consts.svh */
`ifndef AUD_CONSTS_SVH
`define AUD_CONSTS_SVH

// bits per audio sample.
`define AUD_SAMPLE_W 16

// sample words held on chip.
`define AUD_RAM_DEPTH 64

// word address width, log2 of the depth.
`define AUD_ADDR_W 6

`endif
